// File: organ.f
organ_pkg.sv
note_if.sv
note_decoder.sv
tone_generator.sv
led_sweeper.sv
organ_top.sv
organ_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build organ_tb with Verilator and run it"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --top-module organ_tb -f organ.f -o organ_sim
	./obj_dir/organ_sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: organ_tb.sv
module organ_tb
  import organ_pkg::*;
();

  localparam int unsigned LED_STEP = 50;

  logic clock = 1'b0;
  logic reset;
  note_sel_t note_sel;
  logic tone_enable;
  logic tone;
  audio_sample_t audio_sample;
  note_name_t note_name;
  bcd_freq_t freq_bcd;
  led_t led;

  // Monitor state updated on each rising edge
  note_sel_t prev_sel;
  logic prev_enable;
  int unsigned since_change;
  logic last_tone;
  int unsigned run_len;
  logic run_clean;
  led_t last_led;
  int unsigned led_age;
  logic moved_up;

  // Expected values
  logic led_up_next;
  led_t led_expected;
  audio_sample_t audio_expected;
  note_name_t name_expected;
  bcd_freq_t bcd_expected;
  int unsigned half_prev;

  organ_top #(
    .led_tick_cycles (LED_STEP)
  ) i_dut (
    .clock (clock),
    .reset (reset),
    .note_sel (note_sel),
    .tone_enable (tone_enable),
    .tone (tone),
    .audio_sample (audio_sample),
    .note_name (note_name),
    .freq_bcd (freq_bcd),
    .led (led)
  );

  always #10 clock = ~clock;

  // ============================================================
  // Reference values
  // ============================================================

  function automatic int unsigned half_period_for(input note_sel_t idx);
    return CLOCK_HZ / (2 * NOTE_HZ[idx]);
  endfunction

  // Four decimal digits of a frequency
  function automatic bcd_freq_t bcd_digits(input logic [31:0] value);
    return {4'(value / 1000 % 10), 4'(value / 100 % 10),
            4'(value / 10 % 10), 4'(value % 10)};
  endfunction

  function automatic note_name_t note_name_for(input note_sel_t idx);
    note_name_t name;
    case (idx)
      3'd0: name = "DO ";
      3'd1: name = "RE ";
      3'd2: name = "ME ";
      3'd3: name = "FA ";
      3'd4: name = "SO ";
      3'd5: name = "LA ";
      3'd6: name = "TI ";
      default: name = "DO2";
    endcase
    return name;
  endfunction

  // Three full tone periods plus settling
  function automatic int unsigned hold_length(input note_sel_t idx);
    return 6 * half_period_for(idx) + 8;
  endfunction

  function automatic int unsigned run_budget();
    int unsigned total;
    total = 3 + 4 + 200;
    for (int unsigned k = 0; k < NOTE_COUNT; k++)
      total = total + hold_length(note_sel_t'(k));
    return total;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "run stopped at the first failing check");
  endtask

  // Hold one note and flip the enable at random gaps
  task automatic play_note(input note_sel_t idx);
    int unsigned left;
    int unsigned gap;
    note_sel = idx;
    left = hold_length(idx);
    while (left > 0)
    begin
      gap = $urandom_range(half_period_for(idx), 1);
      if (gap > left)
        gap = left;
      repeat (gap) @(negedge clock);
      left = left - gap;
      tone_enable = ~tone_enable;
    end
  endtask

  // ============================================================
  // Monitors
  // ============================================================

  // Decoder restarts from note 0 and prev_sel follows it
  always @(posedge clock)
  begin
    if (reset)
    begin
      prev_sel <= '0;
      prev_enable <= 1'b0;
      since_change <= 0;
      last_tone <= 1'b0;
      run_len <= 0;
      run_clean <= 1'b0;
    end
    else
    begin
      prev_sel <= note_sel;
      prev_enable <= tone_enable;
      last_tone <= tone;
      if (tone != last_tone)
      begin
        run_len <= 1;
        // A level is only timed once the counter restart is behind it
        run_clean <= (since_change >= 1);
      end
      else
        run_len <= run_len + 1;
      if (note_sel != prev_sel)
      begin
        since_change <= 0;
        run_clean <= 1'b0;
      end
      else if (since_change < 2)
        since_change <= since_change + 1;
    end
  end

  always @(posedge clock)
  begin
    if (reset)
    begin
      last_led <= led_t'(1);
      led_age <= 0;
      moved_up <= 1'b1;
    end
    else if (led != last_led)
    begin
      last_led <= led;
      led_age <= 1;
      moved_up <= (led > last_led);
    end
    else
      led_age <= led_age + 1;
  end

  always_comb
  begin
    half_prev = half_period_for(prev_sel);
    name_expected = note_name_for(note_sel);
    bcd_expected = bcd_digits(NOTE_HZ[note_sel]);
    audio_expected = (tone && prev_enable) ? SAMPLE_HIGH : SAMPLE_LOW;
    // Turn around only at the ends
    if (last_led[LED_COUNT-1])
      led_up_next = 1'b0;
    else if (last_led[0])
      led_up_next = 1'b1;
    else
      led_up_next = moved_up;
    led_expected = led_up_next ? (last_led << 1) : (last_led >> 1);
  end

  // ============================================================
  // Checks
  // ============================================================

  assert property (@(posedge clock) $fell(reset) |-> led == led_t'(1))
    else
    begin
      $display("error: led after reset got %h expected %h", led, led_t'(1));
      abort_run();
    end

  assert property (@(posedge clock) $fell(reset) |-> !tone)
    else
    begin
      $display("error: tone after reset got %h expected %h", tone, 1'b0);
      abort_run();
    end

  assert property (@(posedge clock) $fell(reset) |-> audio_sample == SAMPLE_LOW)
    else
    begin
      $display("error: audio_sample after reset got %h expected %h", audio_sample, SAMPLE_LOW);
      abort_run();
    end

  assert property (@(posedge clock) disable iff (reset)
    (note_sel == prev_sel) |-> note_name == name_expected)
    else
    begin
      $display("error: note_name got %h expected %h", note_name, name_expected);
      abort_run();
    end

  assert property (@(posedge clock) disable iff (reset)
    (note_sel == prev_sel) |-> freq_bcd == bcd_expected)
    else
    begin
      $display("error: freq_bcd got %h expected %h", freq_bcd, bcd_expected);
      abort_run();
    end

  assert property (@(posedge clock) disable iff (reset)
    (tone != last_tone && run_clean) |-> run_len == half_prev)
    else
    begin
      $display("error: tone level length got %h expected %h", run_len, half_prev);
      abort_run();
    end

  // Catches a tone that stops toggling
  assert property (@(posedge clock) disable iff (reset) run_clean |-> run_len <= half_prev)
    else
    begin
      $display("error: tone level length %h exceeds %h", run_len, half_prev);
      abort_run();
    end

  assert property (@(posedge clock) disable iff (reset) audio_sample == audio_expected)
    else
    begin
      $display("error: audio_sample got %h expected %h", audio_sample, audio_expected);
      abort_run();
    end

  assert property (@(posedge clock) disable iff (reset) $onehot(led))
    else
    begin
      $display("error: led %h is not one-hot", led);
      abort_run();
    end

  assert property (@(posedge clock) disable iff (reset)
    (led != last_led) |-> led == led_expected)
    else
    begin
      $display("error: led got %h expected %h", led, led_expected);
      abort_run();
    end

  assert property (@(posedge clock) disable iff (reset)
    (led != last_led) |-> led_age == LED_STEP)
    else
    begin
      $display("error: led step interval got %h expected %h", led_age, LED_STEP);
      abort_run();
    end

  assert property (@(posedge clock) disable iff (reset) led_age <= LED_STEP)
    else
    begin
      $display("error: led held for %h cycles, step due at %h", led_age, LED_STEP);
      abort_run();
    end

  // ============================================================
  // Stimulus and watchdog
  // ============================================================

  initial
  begin
    note_sel_t order [NOTE_COUNT];
    note_sel_t swap;
    int unsigned pick;
    reset = 1'b1;
    note_sel = '0;
    tone_enable = 1'b0;
    void'($urandom(52));
    for (int unsigned k = 0; k < NOTE_COUNT; k++)
      order[k] = note_sel_t'(k);
    // Shuffle so every note is visited once
    for (int unsigned k = NOTE_COUNT - 1; k > 0; k--)
    begin
      pick = $urandom_range(k, 0);
      swap = order[k];
      order[k] = order[pick];
      order[pick] = swap;
    end
    repeat (3) @(negedge clock);
    reset = 1'b0;
    tone_enable = 1'($urandom_range(1, 0));
    for (int unsigned k = 0; k < NOTE_COUNT; k++)
      play_note(order[k]);
    repeat (4) @(negedge clock);
    $display("Test passed");
    $finish;
  end

  initial
  begin
    int unsigned limit;
    limit = run_budget() * 20;
    #(limit);
    $display("timeout: the note sequence did not finish within %0d time units", limit);
    abort_run();
  end

endmodule

// File: organ_top.sv
module organ_top
  import organ_pkg::*;
#(
  parameter int unsigned led_tick_cycles = DEFAULT_LED_TICK_CYCLES
)
(
  input logic clock,
  input logic reset,
  input note_sel_t note_sel,
  input logic tone_enable,
  output logic tone,
  output audio_sample_t audio_sample,
  output note_name_t note_name,
  output bcd_freq_t freq_bcd,
  output led_t led
);

  note_if note_bus ();

  // ============================================================
  // Note path
  // ============================================================

  note_decoder i_decoder (
    .clock (clock),
    .reset (reset),
    .note_sel (note_sel),
    .note (note_bus.decoder)
  );

  tone_generator i_tone (
    .clock (clock),
    .reset (reset),
    .tone_enable (tone_enable),
    .note (note_bus.player),
    .tone (tone),
    .audio_sample (audio_sample)
  );

  // Display values straight from the decoder
  assign note_name = note_bus.note_name;
  assign freq_bcd = note_bus.freq_bcd;

  // LEDs run on their own
  led_sweeper #(
    .tick_cycles (led_tick_cycles)
  ) i_leds (
    .clock (clock),
    .reset (reset),
    .led (led)
  );

endmodule

// File: led_sweeper.sv
module led_sweeper
  import organ_pkg::*;
#(
  parameter int unsigned tick_cycles = DEFAULT_LED_TICK_CYCLES
)
(
  input logic clock,
  input logic reset,
  output led_t led
);

  logic [31:0] tick_count;
  logic step;
  logic going_up;

  // Step enable once every tick_cycles clocks
  assign step = (tick_count == 32'(tick_cycles - 1));

  always_ff @(posedge clock)
  begin
    if (reset || step)
      tick_count <= '0;
    else
      tick_count <= tick_count + 32'd1;
  end

  // ============================================================
  // Bouncing one-hot pattern
  // ============================================================

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      led <= led_t'(1);
      going_up <= 1'b1;
    end
    else if (step)
    begin
      if (led[LED_COUNT-1])
      begin
        // Top end, turn around
        led <= led >> 1;
        going_up <= 1'b0;
      end
      else if (led[0])
      begin
        led <= led << 1;
        going_up <= 1'b1;
      end
      else if (going_up)
        led <= led << 1;
      else
        led <= led >> 1;
    end
  end

  assert property (@(posedge clock) disable iff (reset) $onehot(led))
    else $error("led %h not one-hot", led);

endmodule

// File: tone_generator.sv
module tone_generator
  import organ_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic tone_enable,
  note_if.player note,
  output logic tone,
  output audio_sample_t audio_sample
);

  half_period_t count;
  half_period_t count_next;
  logic tone_next;

  // Half-period counter restarts on every new note
  always_comb
  begin
    if (note.note_changed)
    begin
      count_next = '0;
      tone_next = 1'b0;
    end
    else if (count >= note.half_period - half_period_t'(1))
    begin
      count_next = '0;
      tone_next = ~tone;
    end
    else
    begin
      count_next = count + half_period_t'(1);
      tone_next = tone;
    end
  end

  // Sample follows the next tone level so both change on the same edge
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      count <= '0;
      tone <= 1'b0;
      audio_sample <= SAMPLE_LOW;
    end
    else
    begin
      count <= count_next;
      tone <= tone_next;
      // Enable gates only the sample and not the counter
      audio_sample <= (tone_next && tone_enable) ? SAMPLE_HIGH : SAMPLE_LOW;
    end
  end

  // Only two levels and the high one only while the tone is high
  assert property (@(posedge clock) disable iff (reset)
    (audio_sample == SAMPLE_HIGH && tone) || audio_sample == SAMPLE_LOW)
    else $error("audio_sample %h out of range", audio_sample);

endmodule

// File: note_decoder.sv
module note_decoder
  import organ_pkg::*;
(
  input logic clock,
  input logic reset,
  input note_sel_t note_sel,
  note_if.decoder note
);

  note_sel_t sel_q;
  logic changed_q;

  // ============================================================
  // Select register and change detect
  // ============================================================

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      sel_q <= '0;
      changed_q <= 1'b0;
    end
    else
    begin
      sel_q <= note_sel;
      // Compare against the value held so far
      changed_q <= (note_sel != sel_q);
    end
  end

  // ============================================================
  // Table lookup on the registered index
  // ============================================================

  always_comb
  begin
    note.half_period = HALF_PERIOD[sel_q];
    note.freq_bcd = NOTE_BCD[sel_q];
    note.note_name = NOTE_NAME[sel_q];
    note.note_changed = changed_q;
  end

  // Switches are slow, so a change pulse never repeats back to back
  assert property (@(posedge clock) disable iff (reset)
    note.note_changed |=> !note.note_changed)
    else $error("note_changed held for two cycles");

endmodule

// File: note_if.sv
interface note_if
  import organ_pkg::*;
();

  // Looked-up values for the selected note
  half_period_t half_period;
  bcd_freq_t freq_bcd;
  note_name_t note_name;

  // One-cycle pulse when the selection moves
  logic note_changed;

  modport decoder (
    output half_period,
    output freq_bcd,
    output note_name,
    output note_changed
  );

  modport player (
    input half_period,
    input freq_bcd,
    input note_name,
    input note_changed
  );

endinterface

// File: organ_pkg.sv
package organ_pkg;

  // ============================================================
  // Clock and note set
  // ============================================================

  localparam int unsigned CLOCK_HZ = 32'd50_000_000;
  localparam int unsigned NOTE_COUNT = 8;

  // Index 0 is DO, index 7 is DO2
  typedef logic [2:0] note_sel_t;

  typedef logic [15:0] half_period_t;
  typedef logic [15:0] bcd_freq_t;
  typedef logic [23:0] note_name_t;
  typedef logic signed [7:0] audio_sample_t;

  // C-major scale in Hz
  localparam logic [31:0] NOTE_HZ [NOTE_COUNT] = '{
    32'd523, 32'd587, 32'd659, 32'd698,
    32'd783, 32'd880, 32'd987, 32'd1046
  };

  // Same frequencies as four BCD digits for the display
  localparam bcd_freq_t NOTE_BCD [NOTE_COUNT] = '{
    16'h0523, 16'h0587, 16'h0659, 16'h0698,
    16'h0783, 16'h0880, 16'h0987, 16'h1046
  };

  // Clock cycles per tone level, truncated
  localparam half_period_t HALF_PERIOD [NOTE_COUNT] = '{
    half_period_t'(CLOCK_HZ / (2 * NOTE_HZ[0])),
    half_period_t'(CLOCK_HZ / (2 * NOTE_HZ[1])),
    half_period_t'(CLOCK_HZ / (2 * NOTE_HZ[2])),
    half_period_t'(CLOCK_HZ / (2 * NOTE_HZ[3])),
    half_period_t'(CLOCK_HZ / (2 * NOTE_HZ[4])),
    half_period_t'(CLOCK_HZ / (2 * NOTE_HZ[5])),
    half_period_t'(CLOCK_HZ / (2 * NOTE_HZ[6])),
    half_period_t'(CLOCK_HZ / (2 * NOTE_HZ[7]))
  };

  // ============================================================
  // ASCII characters for the note names
  // ============================================================

  localparam logic [7:0] CHAR_SPACE = 8'h20;
  localparam logic [7:0] CHAR_2 = 8'h32;
  localparam logic [7:0] CHAR_A = 8'h41;
  localparam logic [7:0] CHAR_D = 8'h44;
  localparam logic [7:0] CHAR_E = 8'h45;
  localparam logic [7:0] CHAR_F = 8'h46;
  localparam logic [7:0] CHAR_I = 8'h49;
  localparam logic [7:0] CHAR_L = 8'h4C;
  localparam logic [7:0] CHAR_M = 8'h4D;
  localparam logic [7:0] CHAR_O = 8'h4F;
  localparam logic [7:0] CHAR_R = 8'h52;
  localparam logic [7:0] CHAR_S = 8'h53;
  localparam logic [7:0] CHAR_T = 8'h54;

  // Three characters per name, first character in the top byte
  localparam note_name_t NOTE_NAME [NOTE_COUNT] = '{
    {CHAR_D, CHAR_O, CHAR_SPACE},
    {CHAR_R, CHAR_E, CHAR_SPACE},
    {CHAR_M, CHAR_E, CHAR_SPACE},
    {CHAR_F, CHAR_A, CHAR_SPACE},
    {CHAR_S, CHAR_O, CHAR_SPACE},
    {CHAR_L, CHAR_A, CHAR_SPACE},
    {CHAR_T, CHAR_I, CHAR_SPACE},
    {CHAR_D, CHAR_O, CHAR_2}
  };

  // ============================================================
  // Audio and LEDs
  // ============================================================

  // Signed square wave levels
  localparam audio_sample_t SAMPLE_HIGH = 8'sh0F;
  localparam audio_sample_t SAMPLE_LOW = 8'sh80;

  localparam int unsigned LED_COUNT = 8;
  typedef logic [LED_COUNT-1:0] led_t;

  // One sweep step per second
  localparam int unsigned DEFAULT_LED_TICK_CYCLES = CLOCK_HZ;

endpackage
